//--- hw/coreControl.sv
// Core control: instruction decode, program counter, one-hot FSM, bus address and write-back
`timescale 1ns/10ps
`include "rv_macros.svh"

module coreControl import rvPkg::*; (
   input  logic       clk,
   input  logic       reset,       // Synchronous, active low
   input  word        memRdata,    // Instruction from the bus
   input  logic       memRbusy,
   input  logic       memWbusy,
   input  word        loadData,    // Aligned load value
   input  byteMask    storeMask,   // Lanes of the pending store
   output word        memAddr,
   output logic       memRstrb,
   output byteMask    memWmask,
   output logic [1:0] accessAddr,  // Low address bits for alignment
   regPort.ctrl       rf,
   aluPort.ctrl       alu
);

   localparam int padWidth = `XLEN - `ADDR_WIDTH;

   instrWord instr;       // Latched instruction
   opcode    op;
   coreState state;
   addrWord  pc;
   addrWord  addrReg;     // Drives the bus address
   addrWord  pcPlus4;
   addrWord  pcPlusImm;
   word      iImm;
   word      sImm;
   word      bImm;
   word      uImm;
   word      jImm;
   logic     isLoad;
   logic     isAluImm;
   logic     isAuipc;
   logic     isStore;
   logic     isAluReg;
   logic     isLui;
   logic     isBranch;
   logic     isJalr;
   logic     isJal;
   logic     isAlu;
   logic     jumpToImm;
   logic     aluPending;  // ALU op issued, busy is meaningful

   // ****************************************
   // Decode
   // ****************************************
   assign op       = opcode'(instr.r.op[6:2]);
   assign isLoad   = (op == opLoad);
   assign isAluImm = (op == opAluImm);
   assign isAuipc  = (op == opAuipc);
   assign isStore  = (op == opStore);
   assign isAluReg = (op == opAluReg);
   assign isLui    = (op == opLui);
   assign isBranch = (op == opBranch);
   assign isJalr   = (op == opJalr);
   assign isJal    = (op == opJal);
   assign isAlu    = isAluImm | isAluReg;

   // Immediates, one per format view
   assign iImm = {{20{instr.i.imm[11]}}, instr.i.imm};
   assign sImm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
   assign bImm = {{20{instr.b.immSign}}, instr.b.immBit11, instr.b.immMid,
                  instr.b.immLow, 1'b0};
   assign uImm = {instr.u.imm, 12'b0};
   assign jImm = {{12{instr.j.immSign}}, instr.j.immHigh, instr.j.immBit11,
                  instr.j.immLow, 1'b0};

   // Register file indices straight from the latched word
   assign rf.rs1 = instr.r.rs1;
   assign rf.rs2 = instr.r.rs2;
   assign rf.rd  = instr.r.rd;

   // ALU operands, rs1 always first
   assign alu.in1    = rf.rs1Data;
   assign alu.in2    = (isAluReg | isBranch) ? rf.rs2Data : (isStore ? sImm : iImm);
   assign alu.funct3 = instr.r.funct3;
   assign alu.altOp  = instr.r.funct7[5] & (isAluReg | (instr.r.funct3 == 3'b101));
   assign alu.aluWr  = state[execute] & isAlu;

   // PC adders
   assign pcPlus4   = pc + addrWord'(4);
   assign pcPlusImm = pc + (isJal   ? jImm[`ADDR_WIDTH-1:0] :
                            isAuipc ? uImm[`ADDR_WIDTH-1:0] :
                                      bImm[`ADDR_WIDTH-1:0]);
   assign jumpToImm = isJal | (isBranch & alu.taken);

   // Write-back select, at most one term active
   assign rf.writeData = (isLui           ? uImm                         : '0) |
                         (isAlu           ? alu.out                      : '0) |
                         (isAuipc         ? {{padWidth{1'b0}}, pcPlusImm} : '0) |
                         (isJal | isJalr  ? {{padWidth{1'b0}}, pcPlus4}   : '0) |
                         (isLoad          ? loadData                     : '0);
   assign rf.writeBack = ~(isBranch | isStore) & (state[execute] | state[waitAluOrMem]);

   // Bus side
   assign memAddr    = {{padWidth{1'b0}}, addrReg};
   assign accessAddr = addrReg[1:0];
   assign memRstrb   = state[fetchInstr] | state[load];
   assign memWmask   = {4{state[store]}} & storeMask;   // One cycle only

   // ****************************************
   // State machine
   // ****************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state      <= coreState'(1 << waitAluOrMem);   // Wait for both busy levels
         pc         <= addrWord'(`RESET_ADDR);
         aluPending <= 1'b0;
      end else begin
         case (1'b1)
            state[fetchInstr]: state <= coreState'(1 << waitInstr);
            state[waitInstr]: begin
               if (!memRbusy) begin
                  instr <= memRdata;
                  state <= coreState'(1 << fetchRegs);
               end
            end
            state[fetchRegs]: state <= coreState'(1 << execute);   // Reads in flight
            state[execute]: begin
               aluPending <= isAlu;
               pc <= isJalr    ? {alu.plus[`ADDR_WIDTH-1:1], 1'b0} :
                     jumpToImm ? pcPlusImm : pcPlus4;
               // Next fetch address, or the load/store address
               addrReg <= (isLoad | isStore) ? alu.plus[`ADDR_WIDTH-1:0] :
                          isJalr             ? {alu.plus[`ADDR_WIDTH-1:1], 1'b0} :
                          jumpToImm          ? pcPlusImm : pcPlus4;
               state <= {isStore,                        // store
                         isAlu,                          // waitAluOrMem
                         isLoad,                         // load
                         3'b000,
                         !(isStore | isAlu | isLoad)};   // fetchInstr
            end
            state[load], state[store]: state <= coreState'(1 << waitAluOrMem);
            state[waitAluOrMem]: begin
               if (!(aluPending & alu.busy) & !memRbusy & !memWbusy) begin
                  addrReg <= pc;
                  state   <= coreState'(1 << fetchInstr);
               end
            end
            default: state <= coreState'(1 << waitAluOrMem);   // Lost one-hot, recover
         endcase
      end
   end

endmodule

//--- hw/coreIfs.sv
// Internal core interfaces: register file port and ALU port
`timescale 1ns/10ps

// ****************************************
// Register file port
// ****************************************
interface regPort import rvPkg::*; ();
   regIdx rs1;         // Read index A, sampled every cycle
   regIdx rs2;         // Read index B
   regIdx rd;          // Write index
   logic  writeBack;   // Write enable
   word   writeData;
   word   rs1Data;     // Valid one cycle after the index
   word   rs2Data;

   modport ctrl (output rs1, rs2, rd, writeBack, writeData, input rs1Data, rs2Data);
   modport rf   (input rs1, rs2, rd, writeBack, writeData, output rs1Data, rs2Data);
endinterface

// ****************************************
// ALU port
// ****************************************
interface aluPort import rvPkg::*; ();
   logic       aluWr;    // Start pulse, one cycle in execute
   word        in1;
   word        in2;
   logic [2:0] funct3;
   logic       altOp;    // SUB or SRA select
   word        out;      // Registered result
   logic       busy;     // Shift still running
   word        plus;     // in1 + in2, combinational
   logic       taken;    // Branch predicate

   modport ctrl (output aluWr, in1, in2, funct3, altOp, input out, busy, plus, taken);
   modport alu  (input aluWr, in1, in2, funct3, altOp, output out, busy, plus, taken);
endinterface

//--- hw/loadStoreAlign.sv
// Load and store lane alignment: byte and halfword extract, sign extension, store lanes and mask
`timescale 1ns/10ps

module loadStoreAlign import rvPkg::*; (
   input  logic [2:0] funct3,      // Size in [1:0], unsigned load in [2]
   input  logic [1:0] accessAddr,  // Byte offset in the word
   input  word        memRdata,
   input  word        rs2Data,     // Store source
   output word        loadData,
   output word        memWdata,
   output byteMask    storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Load path
   assign loadHalf = accessAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = accessAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;   // Full word

   // Store data, low byte and halfword copied into the upper lanes
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = accessAddr[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = accessAddr[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = accessAddr[0] ? rs2Data[7:0] :
                            accessAddr[1] ? rs2Data[15:8] : rs2Data[31:24];

   // Lane mask
   assign storeMask = byteAccess ? (byteMask'(1) << accessAddr) :
                      halfAccess ? (accessAddr[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

endmodule

//--- hw/quarkCore.sv
// RV32I core top level: control, register file, serial ALU and load/store alignment on one bus
`timescale 1ns/10ps

module quarkCore import rvPkg::*; (
   input  logic    clk,
   input  logic    reset,      // Synchronous, active low
   output word     memAddr,
   output word     memWdata,
   output byteMask memWmask,   // Nonzero only in the store cycle
   input  word     memRdata,   // Instructions and load data
   output logic    memRstrb,
   input  logic    memRbusy,
   input  logic    memWbusy
);

   regPort     rfBus ();
   aluPort     aluBus ();
   word        loadData;
   byteMask    storeMask;
   logic [1:0] accessAddr;

   coreControl control_i (
      .clk        (clk),
      .reset      (reset),
      .memRdata   (memRdata),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .loadData   (loadData),
      .storeMask  (storeMask),
      .memAddr    (memAddr),
      .memRstrb   (memRstrb),
      .memWmask   (memWmask),
      .accessAddr (accessAddr),
      .rf         (rfBus.ctrl),
      .alu        (aluBus.ctrl)
   );

   regFile regFile_i (
      .clk (clk),
      .rf  (rfBus.rf)
   );

   serialAlu serialAlu_i (
      .clk (clk),
      .alu (aluBus.alu)
   );

   // Size and sign come from funct3 on the ALU port
   loadStoreAlign align_i (
      .funct3     (aluBus.funct3),
      .accessAddr (accessAddr),
      .memRdata   (memRdata),
      .rs2Data    (rfBus.rs2Data),
      .loadData   (loadData),
      .memWdata   (memWdata),
      .storeMask  (storeMask)
   );

endmodule

//--- hw/regFile.sv
// Register file with two registered read ports and one write port, x0 fixed at zero
`timescale 1ns/10ps
`include "rv_macros.svh"

module regFile import rvPkg::*; (
   input logic clk,
   regPort.rf  rf
);

   word regs [`REG_COUNT];   // x0 slot is never written

   always_ff @(posedge clk) begin
      // Reads land one cycle after the index
      rf.rs1Data <= (rf.rs1 == '0) ? '0 : regs[rf.rs1];
      rf.rs2Data <= (rf.rs2 == '0) ? '0 : regs[rf.rs2];
      if (rf.writeBack && rf.rd != '0) begin
         regs[rf.rd] <= rf.writeData;
      end
   end

endmodule

//--- hw/rvPkg.sv
// Core package: word types, opcode classes, instruction formats and FSM state bits
`include "rv_macros.svh"

package rvPkg;

   typedef logic [`XLEN-1:0]       word;      // One data word
   typedef logic [`ADDR_WIDTH-1:0] addrWord;  // PC and address register
   typedef logic [4:0]             regIdx;    // Register index
   typedef logic [3:0]             byteMask;  // One bit per byte lane

   // Opcode classes, instr[6:2]
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,  // rd <- mem[rs1+I]
      opAluImm = 5'b00100,  // rd <- rs1 op I
      opAuipc  = 5'b00101,  // rd <- PC + U
      opStore  = 5'b01000,  // mem[rs1+S] <- rs2
      opAluReg = 5'b01100,  // rd <- rs1 op rs2
      opLui    = 5'b01101,  // rd <- U
      opBranch = 5'b11000,  // PC <- PC + B when taken
      opJalr   = 5'b11001,  // rd <- PC+4, PC <- rs1 + I
      opJal    = 5'b11011   // rd <- PC+4, PC <- PC + J
   } opcode;

   // One instruction word, six ways to read it
   typedef union packed {
      struct packed {logic [6:0] funct7; regIdx rs2; regIdx rs1;
                     logic [2:0] funct3; regIdx rd; logic [6:0] op;} r;
      struct packed {logic [11:0] imm; regIdx rs1;
                     logic [2:0] funct3; regIdx rd; logic [6:0] op;} i;
      struct packed {logic [6:0] immHi; regIdx rs2; regIdx rs1;
                     logic [2:0] funct3; logic [4:0] immLo; logic [6:0] op;} s;
      struct packed {logic immSign; logic [5:0] immMid; regIdx rs2; regIdx rs1;
                     logic [2:0] funct3; logic [3:0] immLow; logic immBit11;
                     logic [6:0] op;} b;
      struct packed {logic [19:0] imm; regIdx rd; logic [6:0] op;} u;
      struct packed {logic immSign; logic [9:0] immLow; logic immBit11;
                     logic [7:0] immHigh; regIdx rd; logic [6:0] op;} j;
   } instrWord;

   // One-hot FSM vector and its bit positions
   typedef logic [6:0] coreState;
   localparam int fetchInstr   = 0;  // Address on bus, instruction in flight
   localparam int waitInstr    = 1;  // Latch instruction once read busy drops
   localparam int fetchRegs    = 2;  // Register reads in flight
   localparam int execute      = 3;
   localparam int load         = 4;  // Load address on bus
   localparam int waitAluOrMem = 5;
   localparam int store        = 6;  // Write mask active

endpackage

//--- hw/rv_macros.svh
// Core sizing constants: data width, address register width, reset vector, register count
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path width
`define XLEN 32

// Internal address registers, upper bus bits read zero
`define ADDR_WIDTH 24

// First fetch address after reset
`define RESET_ADDR 32'h0000_0000

`define REG_COUNT 32   // Integer registers x0..x31

`endif

//--- hw/serialAlu.sv
// ALU with one shared subtractor for compares and branches, and a one-bit-per-cycle shifter
`timescale 1ns/10ps
`include "rv_macros.svh"

module serialAlu import rvPkg::*; (
   input logic  clk,
   aluPort.alu  alu
);

   word              aluReg;   // Result, also the shift register
   logic [4:0]       shamt;    // Remaining shift steps
   logic [`XLEN:0]   minus;    // in1 - in2 with borrow on top
   logic             lt;
   logic             ltu;
   logic             eq;

   // ****************************************
   // Adder and compare
   // ****************************************
   assign alu.plus = alu.in1 + alu.in2;

   // Single 33-bit subtract covers SUB, LT, LTU and EQ
   assign minus = {1'b1, ~alu.in2} + {1'b0, alu.in1} + 1'b1;
   assign ltu   = minus[`XLEN];
   assign lt    = (alu.in1[`XLEN-1] ^ alu.in2[`XLEN-1]) ? alu.in1[`XLEN-1] : ltu;
   assign eq    = (minus[`XLEN-1:0] == '0);

   // Branch predicate from funct3
   always_comb begin
      case (alu.funct3)
         3'b000:  alu.taken = eq;    // BEQ
         3'b001:  alu.taken = !eq;   // BNE
         3'b100:  alu.taken = lt;    // BLT
         3'b101:  alu.taken = !lt;   // BGE
         3'b110:  alu.taken = ltu;   // BLTU
         3'b111:  alu.taken = !ltu;  // BGEU
         default: alu.taken = 1'b0;
      endcase
   end

   assign alu.out  = aluReg;
   assign alu.busy = |shamt;

   // ****************************************
   // Operation register and shifter
   // ****************************************
   always_ff @(posedge clk) begin
      if (alu.aluWr) begin
         shamt <= '0;   // Non-shift ops finish at once
         case (alu.funct3)
            3'b000: aluReg <= alu.altOp ? minus[`XLEN-1:0] : alu.plus;  // ADD / SUB
            3'b010: aluReg <= word'(lt);                                 // SLT
            3'b011: aluReg <= word'(ltu);                                // SLTU
            3'b100: aluReg <= alu.in1 ^ alu.in2;
            3'b110: aluReg <= alu.in1 | alu.in2;
            3'b111: aluReg <= alu.in1 & alu.in2;
            default: begin
               // SLL, SRL, SRA: load operand and step count
               aluReg <= alu.in1;
               shamt  <= alu.in2[4:0];
            end
         endcase
      end else if (|shamt) begin
         shamt <= shamt - 5'd1;
         // Right shift fills with sign only for SRA
         aluReg <= alu.funct3[2] ? {alu.altOp & aluReg[`XLEN-1], aluReg[`XLEN-1:1]}
                                 : {aluReg[`XLEN-2:0], 1'b0};
      end
   end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f tb.f --top-module coreTb -Mdir obj_dir -o coreSim

out=$(./obj_dir/coreSim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
fi
exit 1

//--- tb.f
+incdir+hw
hw/rvPkg.sv
hw/coreIfs.sv
hw/regFile.sv
hw/serialAlu.sv
hw/loadStoreAlign.sv
hw/coreControl.sv
hw/quarkCore.sv
test/coreChk.sv
test/coreTb.sv

//--- test/coreChk.sv
// Bus legality checker for the core memory port, bound into the core top level
`timescale 1ns/10ps

module coreChk import rvPkg::*; (
   input logic    clk,
   input logic    reset,
   input word     memAddr,
   input byteMask memWmask,
   input logic    memRstrb
);

   // Read and write never share a cycle
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && memWmask != '0))
      else $error("Read strobe and write mask active in the same cycle");

   // Byte, halfword or word lane patterns only
   assert property (@(posedge clk) disable iff (!reset)
                    memWmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                     4'b0011, 4'b1100, 4'b1111})
      else $error("Illegal write mask %b", memWmask);

   // Memory answers a strobe one cycle later, address must hold
   assert property (@(posedge clk) disable iff (!reset) memRstrb |=> $stable(memAddr))
      else $error("Bus address moved to %h right after a read strobe", memAddr);

endmodule

bind quarkCore coreChk chk_i (
   .clk      (clk),
   .reset    (reset),
   .memAddr  (memAddr),
   .memWmask (memWmask),
   .memRstrb (memRstrb)
);

//--- test/coreTb.sv
// Core testbench: memory model with random busy levels, program table and expected-store checks
`timescale 1ns/10ps

module coreTb import rvPkg::*; ();

   localparam int memWords = 256;          // 1 KB, program low and data at dataBase
   localparam int dataBase = 512;
   localparam logic [6:0] luiOpc   = 7'b0110111;
   localparam logic [6:0] auipcOpc = 7'b0010111;
   localparam logic [6:0] jalrOpc  = 7'b1100111;
   localparam logic [6:0] loadOpc  = 7'b0000011;
   localparam logic [6:0] immOpc   = 7'b0010011;

   logic    clk;
   logic    reset;
   word     memAddr;
   word     memWdata;
   byteMask memWmask;
   logic    memRstrb;
   word     memRdata = '0;
   logic    memRbusy = 1'b1;               // Busy through reset
   logic    memWbusy = 1'b1;

   word         mem [memWords];
   string       progName [$];              // Program table
   word         progWord [$];
   string       expName [$];               // Expected stores, in bus order
   word         expAddr [$];
   word         expData [$];
   byteMask     expMask [$];
   int          slot = 0;                  // Next result offset from dataBase
   int          storeCount = 0;
   int          valueErrors = 0;
   int          missingStores = 0;
   int          extraStores = 0;
   int          readWait = 2;              // Busy cycles left
   int          writeWait = 3;
   int unsigned lcgState = 20;
   word         haltAddr;
   bit          done = 1'b0;
   bit          timedOut = 1'b0;

   quarkCore dut_i (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRdata (memRdata),
      .memRstrb (memRstrb),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int unsigned nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState >> 16;   // High bits are the better ones
   endfunction

   // ****************************************
   // RV32I instruction encoders
   // ****************************************
   function automatic word encR(input logic [6:0] f7, input int rs2, input int rs1,
                                input logic [2:0] f3, input int rd);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
   endfunction

   function automatic word encI(input int imm, input int rs1, input logic [2:0] f3,
                                input int rd, input logic [6:0] opc);
      return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
   endfunction

   function automatic word encS(input int imm, input int rs2, input int rs1,
                                input logic [2:0] f3);
      logic [11:0] i;
      i = 12'(imm);
      return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], 7'b0100011};
   endfunction

   function automatic word encB(input int imm, input int rs1, input int rs2,
                                input logic [2:0] f3);
      logic [12:0] i;
      i = 13'(imm);
      return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
   endfunction

   function automatic word encU(input int imm20, input int rd, input logic [6:0] opc);
      return {20'(imm20), 5'(rd), opc};
   endfunction

   function automatic word encJ(input int imm, input int rd);
      logic [20:0] i;
      i = 21'(imm);
      return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
   endfunction

   function automatic word progPc();
      return word'(progWord.size() * 4);   // Address of the next table entry
   endfunction

   function automatic word laneMaskOf(input byteMask m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // ****************************************
   // Table builders
   // ****************************************
   task automatic addInstr(input string name, input word w);
      progName.push_back(name);
      progWord.push_back(w);
   endtask

   task automatic addStore(input string name, input int off, input word data,
                           input byteMask mask);
      expName.push_back(name);
      expAddr.push_back(word'(dataBase + off) & ~word'(3));   // Word holding the lanes
      expData.push_back(data);
      expMask.push_back(mask);
   endtask

   task automatic storeResult(input string name, input int rs, input word expected);
      addInstr({name, " sw"}, encS(slot, rs, 1, 3'b010));
      addStore(name, slot, expected, 4'hF);
      slot += 4;
   endtask

   task automatic resultTest(input string name, input word instr, input word expected);
      addInstr(name, instr);
      storeResult(name, 5, expected);   // Results land in x5
   endtask

   // Marker store of x3 right after the branch, skipped when taken
   task automatic branchTest(input string name, input logic [2:0] f3, input int rs1,
                             input int rs2, input bit taken);
      addInstr(name, encB(8, rs1, rs2, f3));
      addInstr({name, " marker"}, encS(slot, 3, 1, 3'b010));
      if (!taken) begin
         addStore(name, slot, 32'd7, 4'hF);
      end
      slot += 4;
   endtask

   task automatic laneTest(input string name, input logic [2:0] f3, input int off,
                           input word data, input byteMask mask);
      addInstr(name, encS(off, 7, 1, f3));   // x7 = A1B2C3D4
      addStore(name, off, data, mask);
   endtask

   task automatic buildProgram();
      word linkPc;
      int  srcOff;
      addInstr("base", encI(dataBase, 0, 3'b000, 1, immOpc));   // x1 data pointer
      addInstr("minus five", encI(-5, 0, 3'b000, 2, immOpc));
      addInstr("seven", encI(7, 0, 3'b000, 3, immOpc));
      resultTest("addi", encI(-5, 0, 3'b000, 5, immOpc), 32'hFFFF_FFFB);
      resultTest("lui", encU(32'h12345, 5, luiOpc), 32'h1234_5000);
      resultTest("add", encR(7'h00, 3, 2, 3'b000, 5), 32'h0000_0002);
      resultTest("sub", encR(7'h20, 2, 3, 3'b000, 5), 32'h0000_000C);
      resultTest("slt negative", encR(7'h00, 3, 2, 3'b010, 5), 32'h0000_0001);
      resultTest("sltu", encR(7'h00, 3, 2, 3'b011, 5), 32'h0000_0000);
      resultTest("xor", encR(7'h00, 3, 2, 3'b100, 5), 32'hFFFF_FFFC);
      resultTest("or", encR(7'h00, 3, 2, 3'b110, 5), 32'hFFFF_FFFF);
      resultTest("and", encR(7'h00, 3, 2, 3'b111, 5), 32'h0000_0003);
      // Shift source x6 = 80001234
      addInstr("shift source hi", encU(32'h80001, 6, luiOpc));
      addInstr("shift source lo", encI(32'h234, 6, 3'b000, 6, immOpc));
      resultTest("slli 0", encI(0, 6, 3'b001, 5, immOpc), 32'h8000_1234);
      resultTest("slli 4", encI(4, 6, 3'b001, 5, immOpc), 32'h0001_2340);
      resultTest("srli 31", encI(31, 6, 3'b101, 5, immOpc), 32'h0000_0001);
      resultTest("srai 31", encI(32'h41F, 6, 3'b101, 5, immOpc), 32'hFFFF_FFFF);
      resultTest("srai 8", encI(32'h408, 6, 3'b101, 5, immOpc), 32'hFF80_0012);
      resultTest("sll 7", encR(7'h00, 3, 6, 3'b001, 5), 32'h0009_1A00);
      resultTest("srl 7", encR(7'h00, 3, 6, 3'b101, 5), 32'h0100_0024);
      resultTest("sra 7", encR(7'h20, 3, 6, 3'b101, 5), 32'hFF00_0024);
      // Lane stores of x7
      addInstr("store source hi", encU(32'hA1B2C, 7, luiOpc));
      addInstr("store source lo", encI(32'h3D4, 7, 3'b000, 7, immOpc));
      laneTest("sb lane 0", 3'b000, slot, 32'h0000_00D4, 4'b0001);
      laneTest("sb lane 1", 3'b000, slot + 1, 32'h0000_D400, 4'b0010);
      laneTest("sb lane 2", 3'b000, slot + 2, 32'h00D4_0000, 4'b0100);
      laneTest("sb lane 3", 3'b000, slot + 3, 32'hD400_0000, 4'b1000);
      slot += 4;
      laneTest("sh low", 3'b001, slot, 32'h0000_C3D4, 4'b0011);
      laneTest("sh high", 3'b001, slot + 2, 32'hC3D4_0000, 4'b1100);
      slot += 4;
      srcOff = slot;
      laneTest("sw source", 3'b010, slot, 32'hA1B2_C3D4, 4'b1111);
      slot += 4;
      // Loads of the source word
      resultTest("lb lane 0", encI(srcOff, 1, 3'b000, 5, loadOpc), 32'hFFFF_FFD4);
      resultTest("lbu lane 1", encI(srcOff + 1, 1, 3'b100, 5, loadOpc), 32'h0000_00C3);
      resultTest("lb lane 3", encI(srcOff + 3, 1, 3'b000, 5, loadOpc), 32'hFFFF_FFA1);
      resultTest("lbu lane 2", encI(srcOff + 2, 1, 3'b100, 5, loadOpc), 32'h0000_00B2);
      resultTest("lh low", encI(srcOff, 1, 3'b001, 5, loadOpc), 32'hFFFF_C3D4);
      resultTest("lhu high", encI(srcOff + 2, 1, 3'b101, 5, loadOpc), 32'h0000_A1B2);
      resultTest("lh high", encI(srcOff + 2, 1, 3'b001, 5, loadOpc), 32'hFFFF_A1B2);
      // Branches on x2 = -5, x3 = 7
      branchTest("beq taken", 3'b000, 3, 3, 1'b1);
      branchTest("beq not taken", 3'b000, 2, 3, 1'b0);
      branchTest("bne taken", 3'b001, 2, 3, 1'b1);
      branchTest("bne not taken", 3'b001, 3, 3, 1'b0);
      branchTest("blt taken", 3'b100, 2, 3, 1'b1);
      branchTest("blt not taken", 3'b100, 3, 2, 1'b0);
      branchTest("bge taken", 3'b101, 3, 2, 1'b1);
      branchTest("bge not taken", 3'b101, 2, 3, 1'b0);
      branchTest("bltu taken", 3'b110, 3, 2, 1'b1);
      branchTest("bltu not taken", 3'b110, 2, 3, 1'b0);
      branchTest("bgeu taken", 3'b111, 2, 3, 1'b1);
      branchTest("bgeu not taken", 3'b111, 3, 2, 1'b0);
      // JAL over one store, link in x5
      linkPc = progPc();
      addInstr("jal", encJ(8, 5));
      addInstr("jal skipped", encS(slot, 3, 1, 3'b010));
      slot += 4;
      storeResult("jal link", 5, linkPc + 32'd4);
      // JALR from an AUIPC base, target three words on
      linkPc = progPc();
      addInstr("jalr base", encU(0, 11, auipcOpc));
      addInstr("jalr", encI(12, 11, 3'b000, 5, jalrOpc));
      addInstr("jalr skipped", encS(slot, 3, 1, 3'b010));
      slot += 4;
      storeResult("jalr link", 5, linkPc + 32'd8);
      linkPc = progPc();
      resultTest("auipc", encU(1, 5, auipcOpc), linkPc + 32'h1000);
      addInstr("x0 write", encI(123, 0, 3'b000, 0, immOpc));
      storeResult("x0 reads zero", 0, 32'h0);
      haltAddr = progPc();
      addInstr("halt", encJ(0, 0));   // Self loop
   endtask

   // ****************************************
   // Checks
   // ****************************************
   task automatic checkWord(input string name, input word expected, input word actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic checkMask(input string name, input byteMask expected, input byteMask actual);
      if (actual !== expected) begin
         $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic recordStore();
      word expLanes;
      word actLanes;
      if (storeCount >= expName.size()) begin
         $display("Extra store: unexpected write of %h to address %h with mask %b",
                  memWdata, memAddr, memWmask);
         extraStores++;
      end else begin
         expLanes = laneMaskOf(expMask[storeCount]);   // Only enabled lanes matter
         actLanes = laneMaskOf(memWmask);
         checkWord({expName[storeCount], " address"}, expAddr[storeCount],
                   memAddr & ~word'(3));
         checkMask({expName[storeCount], " mask"}, expMask[storeCount], memWmask);
         checkWord({expName[storeCount], " data"}, expData[storeCount] & expLanes,
                   memWdata & actLanes);
      end
      storeCount++;
   endtask

   // Memory model, sampled and driven on the falling edge
   always @(negedge clk) begin
      if (reset) begin
         if (readWait > 0) readWait--;
         if (writeWait > 0) writeWait--;
         if (memRstrb) begin
            memRdata = mem[memAddr[9:2]];   // Read data for the next cycle
            readWait = nextRand() % 3;
            if (memAddr == haltAddr) done = 1'b1;
         end
         if (memWmask != '0) begin
            recordStore();
            for (int b = 0; b < 4; b++) begin
               if (memWmask[b]) mem[memAddr[9:2]][b*8 +: 8] = memWdata[b*8 +: 8];
            end
            writeWait = nextRand() % 3;
         end
         memRbusy = (readWait != 0);
         memWbusy = (writeWait != 0);
      end
   end

   // ****************************************
   // Main sequence
   // ****************************************
   initial begin
      int limit;
      int cycles;
      reset = 1'b0;
      buildProgram();
      for (int i = 0; i < memWords; i++) begin
         mem[i] = word'(i * 4) ^ 32'h5A5A_0000;   // Address-derived fill
      end
      for (int i = 0; i < progWord.size(); i++) begin
         mem[i] = progWord[i];
      end
      limit = progWord.size() * 40 + 200;
      cycles = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      while (!done && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Timeout: core did not reach the halt loop within %0d cycles", limit);
         if (memAddr[9:2] < progName.size()) begin
            $display("Core was last at address %h, instruction %s",
                     memAddr, progName[memAddr[9:2]]);
         end
         timedOut = 1'b1;
      end
      for (int i = storeCount; i < expName.size(); i++) begin
         $display("Missing store: %s never wrote address %h", expName[i], expAddr[i]);
         missingStores++;
      end
      $display("Errors: %0d value, %0d missing stores, %0d extra stores, %0d timeouts",
               valueErrors, missingStores, extraStores, int'(timedOut));
      if (!timedOut && valueErrors == 0 && missingStores == 0 && extraStores == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
